// ==== common/board_pkg.sv ====
package board_pkg;

    //--------------------------------------------------
    // Display geometry

    localparam int w_digit   = 4;   // Hex digits on the board
    localparam int bar_width = 80;  // Pixels per colour bar

    // 640x480 at 60 Hz, in pixels and lines
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;

    //--------------------------------------------------
    // Shared types

    // One scanned digit, active high
    typedef struct packed
    {
        logic dp;
        logic g;
        logic f;
        logic e;
        logic d;
        logic c;
        logic b;
        logic a;
    } seg7_t;

    // One static board digit, active low
    typedef struct packed
    {
        logic       dp;
        logic [6:0] seg;  // Segment a at bit 0
    } hex_out_t;

    typedef struct packed
    {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed
    {
        logic [9:0] x;
        logic [9:0] y;
        logic       display_on;
    } vga_pos_t;

    // Counter opcode from sw[1:0], code 3 falls back to hold
    typedef enum logic [1:0]
    {
        mode_hold = 2'd0,
        mode_up   = 2'd1,
        mode_down = 2'd2
    } count_mode_t;

endpackage

// ==== rtl/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen
#(
    parameter int clk_mhz = 50,
    parameter int tick_hz = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // Clock cycles per tick
    localparam int period = clk_mhz * 1000000 / tick_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt-1:0] cnt;

    // High on the last cycle of each period
    assign tick = (cnt == w_cnt'(period - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (tick)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

endmodule

// ==== vga/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
#(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25
)
(
    input  logic                clk,
    input  logic                rst,
    output board_pkg::vga_pos_t pos,
    output logic                hsync,
    output logic                vsync
);

    import board_pkg::*;

    localparam int pixel_div = clk_mhz / pixel_mhz;
    localparam int w_div     = pixel_div > 1 ? $clog2(pixel_div) : 1;

    localparam logic [9:0] h_last     = 10'(h_total - 1);
    localparam logic [9:0] v_last     = 10'(v_total - 1);
    localparam logic [9:0] hs_start   = 10'(h_visible + h_front);
    localparam logic [9:0] hs_end     = 10'(h_visible + h_front + h_sync);
    localparam logic [9:0] vs_start   = 10'(v_visible + v_front);
    localparam logic [9:0] vs_end     = 10'(v_visible + v_front + v_sync);
    localparam logic [9:0] h_vis_last = 10'(h_visible - 1);
    localparam logic [9:0] v_vis_last = 10'(v_visible - 1);

    logic [w_div-1:0] div_cnt;
    logic             pix_en;
    logic [9:0]       h_cnt;
    logic [9:0]       v_cnt;
    logic             hs_q;  // Sync aligned with pos
    logic             vs_q;

    //--------------------------------------------------
    // Pixel enable and raster counters

    assign pix_en = (div_cnt == w_div'(pixel_div - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (pix_en)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (pix_en)
        begin
            if (h_cnt == h_last)
            begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == v_last) ? 10'd0 : v_cnt + 10'd1;  // Next line
            end
            else
                h_cnt <= h_cnt + 10'd1;
        end
    end

    //--------------------------------------------------
    // Registered position and sync

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pos   <= '0;
            hs_q  <= 1'b1;
            vs_q  <= 1'b1;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            pos.x          <= h_cnt;
            pos.y          <= v_cnt;
            pos.display_on <= (h_cnt <= h_vis_last) && (v_cnt <= v_vis_last);
            hs_q           <= !((h_cnt >= hs_start) && (h_cnt < hs_end));
            vs_q           <= !((v_cnt >= vs_start) && (v_cnt < vs_end));
            // Extra stage matches the registered colour in lab_top
            hsync          <= hs_q;
            vsync          <= vs_q;
        end
    end

    // Sync pulse must sit inside blanking once colour latency is applied
    a_sync_in_blank: assert property (@(posedge clk) disable iff (rst)
        pos.display_on |=> hsync);

    a_h_cnt_range: assert property (@(posedge clk) disable iff (rst)
        h_cnt < h_total);

endmodule

// ==== seven_seg/seg7_scanner.sv ====
`timescale 1ns/1ps

module seg7_scanner
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          scan_tick,
    input  logic [15:0]                   value,
    output board_pkg::seg7_t              seg,
    output logic [board_pkg::w_digit-1:0] digit
);

    import board_pkg::*;

    logic [3:0] nibble;

    // Hex glyphs, bit order g..a
    function automatic logic [6:0] hex_glyph(input logic [3:0] h);
        case (h)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;  // Lower case b
            4'hC: return 7'h39;
            4'hD: return 7'h5E;  // Lower case d
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // Rotate the active digit left
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            digit <= w_digit'(1);
        else if (scan_tick)
            digit <= {digit[w_digit-2:0], digit[w_digit-1]};
    end

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < w_digit; i++)
        begin
            if (digit[i])
                nibble = value[i*4 +: 4];
        end
    end

    assign seg = seg7_t'({1'b0, hex_glyph(nibble)});  // Decimal point off

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(digit));

endmodule

// ==== seven_seg/seg7_static_hold.sv ====
`timescale 1ns/1ps

module seg7_static_hold
(
    input  logic                                         clk,
    input  logic                                         rst,
    input  board_pkg::seg7_t                             seg,
    input  logic [board_pkg::w_digit-1:0]                digit,
    output board_pkg::hex_out_t [board_pkg::w_digit-1:0] hex
);

    import board_pkg::*;

    hex_out_t hex_next;

    // Board digits are active low
    assign hex_next.seg = ~{seg.g, seg.f, seg.e, seg.d, seg.c, seg.b, seg.a};
    assign hex_next.dp  = ~seg.dp;

    //--------------------------------------------------
    // Sticky flops

    // Each digit keeps its last scanned value, so the static display
    // is driven all the time and stays at full brightness
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            hex <= '1;  // Blank
        else
        begin
            for (int i = 0; i < w_digit; i++)
            begin
                if (digit[i])
                    hex[i] <= hex_next;
            end
        end
    end

endmodule

// ==== rtl/lab_top.sv ====
`timescale 1ns/1ps

module lab_top
#(
    parameter int clk_mhz = 50,
    parameter int tick_hz = 4,
    parameter int scan_hz = 1000
)
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [2:0]                    key,
    input  logic [8:0]                    sw,
    input  board_pkg::vga_pos_t           pos,
    output logic [9:0]                    led,
    output board_pkg::rgb_t               rgb,
    output board_pkg::seg7_t              seg,
    output logic [board_pkg::w_digit-1:0] digit
);

    import board_pkg::*;

    logic        count_tick;
    logic        scan_tick;
    count_mode_t mode;
    logic [15:0] count;
    seg7_t       scan_seg;
    logic        spare_on;
    logic [2:0]  bar_idx;

    function automatic rgb_t bar_palette(input logic [2:0] idx);
        case (idx)
            3'd0: return '{4'd15, 4'd15, 4'd15};  // White
            3'd1: return '{4'd15, 4'd15, 4'd0};   // Yellow
            3'd2: return '{4'd0,  4'd15, 4'd15};  // Cyan
            3'd3: return '{4'd0,  4'd15, 4'd0};
            3'd4: return '{4'd15, 4'd0,  4'd15};  // Magenta
            3'd5: return '{4'd15, 4'd0,  4'd0};
            3'd6: return '{4'd0,  4'd0,  4'd15};
            default: return '{4'd8, 4'd8, 4'd8};  // Grey
        endcase
    endfunction

    tick_gen #(.clk_mhz(clk_mhz), .tick_hz(tick_hz))
    i_count_tick (.clk(clk), .rst(rst), .tick(count_tick));

    tick_gen #(.clk_mhz(clk_mhz), .tick_hz(scan_hz))
    i_scan_tick (.clk(clk), .rst(rst), .tick(scan_tick));

    //--------------------------------------------------
    // Counter

    always_comb
    begin
        case (sw[1:0])
            2'd1:    mode = mode_up;
            2'd2:    mode = mode_down;
            default: mode = mode_hold;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else if (key[0])
            count <= '0;  // Clear wins over stepping
        else if (count_tick)
        begin
            case (mode)
                mode_up:   count <= count + 16'd1;
                mode_down: count <= count - 16'd1;
                default:   count <= count;
            endcase
        end
    end

    assign led = count[9:0];

    //--------------------------------------------------
    // Digits and colour bars

    seg7_scanner i_seg7_scanner
    (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .value     (count),
        .seg       (scan_seg),
        .digit     (digit)
    );

    // Decimal points flag any spare switch or button
    assign spare_on = |{key[2:1], sw[8:2]};

    always_comb
    begin
        seg    = scan_seg;
        seg.dp = spare_on;
    end

    assign bar_idx = 3'(pos.x / bar_width);

    always_ff @(posedge clk)
    begin
        rgb <= bar_palette(bar_idx);  // One cycle behind pos
    end

endmodule

// ==== rtl/board_top.sv ====
`timescale 1ns/1ps

module board_top
#(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25,
    parameter int tick_hz   = 4,
    parameter int scan_hz   = 1000
)
(
    input  logic                                         clk,
    input  logic [2:0]                                   button,
    input  logic [9:0]                                   sw,
    output logic [9:0]                                   ledg,
    output board_pkg::hex_out_t [board_pkg::w_digit-1:0] hex,
    output logic                                         vga_hs,
    output logic                                         vga_vs,
    output board_pkg::rgb_t                              vga_rgb
);

    import board_pkg::*;

    logic               rst;
    logic [2:0]         key;
    vga_pos_t           pos;
    rgb_t               lab_rgb;
    seg7_t              seg;
    logic [w_digit-1:0] digit;
    logic               display_on_d;  // Aligned with lab_rgb

    //--------------------------------------------------
    // Pin mapping

    assign rst = sw[9];     // Top switch is the reset
    assign key = ~button;   // Buttons are active low

    vga_timing
    #(
        .clk_mhz   (clk_mhz),
        .pixel_mhz (pixel_mhz)
    )
    i_vga_timing
    (
        .clk   (clk),
        .rst   (rst),
        .pos   (pos),
        .hsync (vga_hs),
        .vsync (vga_vs)
    );

    lab_top
    #(
        .clk_mhz (clk_mhz),
        .tick_hz (tick_hz),
        .scan_hz (scan_hz)
    )
    i_lab_top
    (
        .clk   (clk),
        .rst   (rst),
        .key   (key),
        .sw    (sw[8:0]),
        .pos   (pos),
        .led   (ledg),
        .rgb   (lab_rgb),
        .seg   (seg),
        .digit (digit)
    );

    seg7_static_hold i_seg7_static_hold
    (
        .clk   (clk),
        .rst   (rst),
        .seg   (seg),
        .digit (digit),
        .hex   (hex)
    );

    //--------------------------------------------------
    // Blanking

    // Colour lags pos by a cycle, so display_on is delayed to match
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            display_on_d <= 1'b0;
        else
            display_on_d <= pos.display_on;
    end

    assign vga_rgb = display_on_d ? lab_rgb : '0;

endmodule

// ==== dv/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

//--------------------------------------------------
// Reference models

// Hex glyphs as g..a, segments active high
function automatic logic [6:0] seg_encode(input logic [3:0] nibble);
    case (nibble)
        4'h0: return 7'b0111111;
        4'h1: return 7'b0000110;
        4'h2: return 7'b1011011;
        4'h3: return 7'b1001111;
        4'h4: return 7'b1100110;
        4'h5: return 7'b1101101;
        4'h6: return 7'b1111101;
        4'h7: return 7'b0000111;
        4'h8: return 7'b1111111;
        4'h9: return 7'b1101111;
        4'hA: return 7'b1110111;
        4'hB: return 7'b1111100;
        4'hC: return 7'b0111001;
        4'hD: return 7'b1011110;
        4'hE: return 7'b1111001;
        default: return 7'b1110001;  // F
    endcase
endfunction

// Static board digit with the point dark
function automatic hex_out_t hex_expect(input logic [3:0] nibble);
    hex_out_t h;
    h.dp  = 1'b1;
    h.seg = ~seg_encode(nibble);  // Active low on the board
    return h;
endfunction

function automatic rgb_t bar_color(input int idx);
    case (idx)
        0: return rgb_t'(12'hFFF);  // White
        1: return rgb_t'(12'hFF0);  // Yellow
        2: return rgb_t'(12'h0FF);  // Cyan
        3: return rgb_t'(12'h0F0);  // Green
        4: return rgb_t'(12'hF0F);  // Magenta
        5: return rgb_t'(12'hF00);  // Red
        6: return rgb_t'(12'h00F);  // Blue
        default: return rgb_t'(12'h888);
    endcase
endfunction

// Colour seen i cycles after a falling edge of hsync
function automatic rgb_t line_color(input int i);
    int h;
    h = i - (h_sync + h_back);
    if (h < 0 || h >= h_visible)
        return '0;
    return bar_color(h / bar_width);
endfunction

function automatic logic [15:0] next_count(input count_mode_t mode,
                                           input logic [15:0] value);
    case (mode)
        mode_up:   return value + 16'd1;
        mode_down: return value - 16'd1;
        default:   return value;
    endcase
endfunction

//--------------------------------------------------
// Compare tasks

task automatic check_hex(input string name, input hex_out_t exp,
                         input hex_out_t got, inout int errs);
    if (got !== exp)
    begin
        errs++;
        $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
endtask

task automatic check_rgb(input string name, input rgb_t exp,
                         input rgb_t got, inout int errs);
    if (got !== exp)
    begin
        errs++;
        $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
endtask

task automatic check_led(input string name, input logic [9:0] exp,
                         input logic [9:0] got, inout int errs);
    if (got !== exp)
    begin
        errs++;
        $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, exp, got);
    end
endtask

task automatic check_sync(input string name, input logic exp,
                          input logic got, inout int errs);
    if (got !== exp)
    begin
        errs++;
        $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, got);
    end
endtask

// Cycle counts measured on the sync pulses
task automatic check_cycles(input string name, input int exp,
                            input int got, inout int errs);
    if (got != exp)
    begin
        errs++;
        $display("FAIL at %0t: %s expected %0d cycles, got %0d", $time, name, exp, got);
    end
endtask

`endif

// ==== dv/tb_board_top.sv ====
`timescale 1ns/1ps

module tb_board_top;

    import board_pkg::*;

    localparam int clk_mhz   = 1;
    localparam int pixel_mhz = 1;
    localparam int tick_hz   = 50000;
    localparam int scan_hz   = 250000;

    localparam int tick_cycles   = clk_mhz * 1000000 / tick_hz;
    localparam int settle_cycles = 20;  // One full digit scan plus slack
    localparam int up_steps      = 30;
    localparam int down_steps    = 40;  // Goes below zero
    localparam int hold_cycles   = 200;
    localparam int clear_cycles  = 3 * tick_cycles;
    localparam int digit_rounds  = 3;
    localparam int max_ticks     = 119;
    localparam int lines_checked = 3;

    localparam int timeout_cycles = (lines_checked + 1) * h_total
        + (up_steps + down_steps) * tick_cycles + hold_cycles + 2 * clear_cycles
        + digit_rounds * ((max_ticks + 1) * tick_cycles + settle_cycles) + 5000;

    logic                   clk;
    logic [2:0]             button;
    logic [9:0]             sw;
    logic [9:0]             ledg;
    hex_out_t [w_digit-1:0] hex;
    logic                   vga_hs;
    logic                   vga_vs;
    rgb_t                   vga_rgb;

    logic [15:0] model_count;  // Counter rebuilt from the known steps
    integer      seed;
    int          cycle_count = 0;
    int          n_tests;
    int          n_bad_tests;
    int          n_errors;
    bit          vga_done;
    int          vga_timing_errs;
    int          vga_colour_errs;

    `include "tb_ref.svh"

    board_top
    #(
        .clk_mhz   (clk_mhz),
        .pixel_mhz (pixel_mhz),
        .tick_hz   (tick_hz),
        .scan_hz   (scan_hz)
    )
    i_board_top
    (
        .clk     (clk),
        .button  (button),
        .sw      (sw),
        .ledg    (ledg),
        .hex     (hex),
        .vga_hs  (vga_hs),
        .vga_vs  (vga_vs),
        .vga_rgb (vga_rgb)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Time %0t: run stopped at the limit of %0d cycles", $time, cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    //--------------------------------------------------
    // Helpers

    task automatic print_result(input string name, input int errs);
        if (errs == 0)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errs);
    endtask

    task automatic tally_result(input int errs);
        n_tests++;
        n_errors += errs;
        if (errs != 0)
            n_bad_tests++;
    endtask

    task automatic close_test(input string name, input int errs);
        print_result(name, errs);
        tally_result(errs);
    endtask

    task automatic wait_led_change(input int limit, output logic [9:0] value, output bit seen);
        logic [9:0] start;
        int         n;
        start = ledg;
        seen  = 1'b0;
        n     = 0;
        while (!seen && n < limit)
        begin
            @(negedge clk);
            n++;
            seen = (ledg !== start);
        end
        value = ledg;
    endtask

    // Sets the mode and follows the given number of counter steps
    task automatic count_steps(input count_mode_t mode, input int steps, inout int errs);
        logic [9:0] now;
        bit         seen;
        @(negedge clk);
        sw[1:0] = mode;
        for (int i = 0; i < steps; i++)
        begin
            wait_led_change(2 * tick_cycles, now, seen);
            if (!seen)
            begin
                $display("Time %0t: ledg made no step within %0d cycles in %s",
                         $time, 2 * tick_cycles, mode.name());
                errs++;
                return;
            end
            model_count = next_count(mode, model_count);
            check_led("ledg", model_count[9:0], now, errs);
            if (errs != 0)
                return;
        end
    endtask

    //--------------------------------------------------
    // Main sequence

    initial
    begin
        int errs;
        int n;
        int steps;
        clk         = 1'b0;
        button      = 3'b111;   // Released
        sw          = 10'h200;  // Reset switch up
        seed        = 32'h5f30;
        model_count = '0;
        n_tests     = 0;
        n_bad_tests = 0;
        n_errors    = 0;

        errs = 0;
        repeat (3)
        begin
            @(negedge clk);
            for (int d = 0; d < w_digit; d++)
                check_hex($sformatf("hex[%0d]", d), '1, hex[d], errs);
            check_led("ledg", '0, ledg, errs);
            check_rgb("vga_rgb", '0, vga_rgb, errs);
            check_sync("vga_hs", 1'b1, vga_hs, errs);
            check_sync("vga_vs", 1'b1, vga_vs, errs);
        end
        sw[9] = 1'b0;
        close_test("reset_state", errs);

        errs = 0;
        count_steps(mode_up, up_steps, errs);
        close_test("count_up", errs);

        errs = 0;
        count_steps(mode_down, down_steps, errs);
        close_test("count_down", errs);

        errs = 0;
        @(negedge clk);
        sw[1:0] = mode_hold;
        for (int i = 0; i < hold_cycles && errs == 0; i++)
        begin
            @(negedge clk);
            check_led("ledg", model_count[9:0], ledg, errs);
        end
        close_test("count_hold", errs);

        // Clear while counting up
        errs = 0;
        @(negedge clk);
        sw[1:0]   = mode_up;
        button[0] = 1'b0;
        n = 0;
        while (ledg !== 10'd0 && n < tick_cycles)
        begin
            @(negedge clk);
            n++;
        end
        if (ledg !== 10'd0)
        begin
            $display("Time %0t: ledg not cleared %0d cycles after pressing button[0]",
                     $time, tick_cycles);
            errs++;
        end
        for (int i = 0; i < clear_cycles && errs == 0; i++)
        begin
            @(negedge clk);
            check_led("ledg", 10'd0, ledg, errs);
        end
        @(negedge clk);
        button[0]   = 1'b1;
        sw[1:0]     = mode_hold;
        model_count = '0;
        close_test("clear", errs);

        errs = 0;
        for (int r = 0; r < digit_rounds; r++)
        begin
            steps = 20 + int'($unsigned($random(seed)) % 100);
            count_steps(mode_up, steps, errs);
            sw[1:0] = mode_hold;
            repeat (settle_cycles) @(negedge clk);
            for (int d = 0; d < w_digit; d++)
                check_hex($sformatf("hex[%0d]", d), hex_expect(model_count[d*4 +: 4]),
                          hex[d], errs);
        end
        close_test("static_digits", errs);

        wait (vga_done);
        tally_result(vga_timing_errs);
        tally_result(vga_colour_errs);
        $display("Tests: %0d run, %0d failed, %0d errors", n_tests, n_bad_tests, n_errors);
        if (n_bad_tests == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    //--------------------------------------------------
    // VGA line monitor

    // Lines are measured from one hsync fall to the next
    initial
    begin : vga_monitor
        int   since_fall;
        int   low_len;
        int   falls;
        int   prev_errs;
        logic hs_prev;
        bit   line_bad;
        vga_done        = 1'b0;
        vga_timing_errs = 0;
        vga_colour_errs = 0;
        since_fall      = 0;
        low_len         = 0;
        falls           = 0;
        line_bad        = 1'b0;
        @(negedge clk);  // Reset switch is up by now
        wait (sw[9] === 1'b0);
        hs_prev = vga_hs;
        while (falls <= lines_checked)
        begin
            @(negedge clk);
            since_fall++;
            if (hs_prev && !vga_hs)
            begin
                if (falls > 0)
                    check_cycles("vga_hs period", h_total, since_fall, vga_timing_errs);
                falls++;
                since_fall = 0;
                low_len    = 0;
                line_bad   = 1'b0;
            end
            if (!vga_hs)
                low_len++;
            else if (!hs_prev && falls > 0)
                check_cycles("vga_hs low time", h_sync, low_len, vga_timing_errs);
            if (falls > 0 && falls <= lines_checked && !line_bad)
            begin
                prev_errs = vga_colour_errs;
                check_rgb("vga_rgb", line_color(since_fall), vga_rgb, vga_colour_errs);
                line_bad = (vga_colour_errs != prev_errs);  // One report per line
            end
            if (since_fall > 2 * h_total)
            begin
                $display("Time %0t: vga_hs had no falling edge for %0d cycles",
                         $time, since_fall);
                vga_timing_errs++;
                falls = lines_checked + 1;
            end
            hs_prev = vga_hs;
        end
        print_result("line_timing", vga_timing_errs);
        print_result("colour_bars", vga_colour_errs);
        vga_done = 1'b1;
    end

endmodule

// ==== build.f ====
+incdir+dv
common/board_pkg.sv
rtl/tick_gen.sv
vga/vga_timing.sv
seven_seg/seg7_scanner.sv
seven_seg/seg7_static_hold.sv
rtl/lab_top.sv
rtl/board_top.sv
dv/tb_board_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_board_top \
    -f build.f

./obj_dir/Vtb_board_top 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
